// ==== all.f ====
+incdir+.
dcache_adapter_pkg.sv
axi_port_if.sv
dcache_port_if.sv
axi_skid_buffer.sv
axi_dcache_adapter.sv
dcache_word_mem.sv
dcache_adapter_top.sv
tb_dcache_adapter_sva.sv
tb_dcache_adapter.sv

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f \
    --top-module tb_dcache_adapter -o sim_dcache_adapter

./obj_dir/sim_dcache_adapter 2>&1 | tee sim.log

if grep -q "Result: FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
echo "simulation finished cleanly"

// ==== tb_dcache_adapter.sv ====
`timescale 1ns/1ps

`include "dcache_adapter_defines.svh"

module tb_dcache_adapter
    import dcache_adapter_pkg::*;
();

    localparam int CLK_PERIOD   = 8;
    localparam int HOLD_CYCLES  = 6;
    localparam int RAND_TRANS   = 30;
    // reset 1, full 2, partial 5, order 4, stall 3, plus random traffic
    localparam int NUM_TRANS    = 15 + RAND_TRANS;
    localparam int TRANS_BUDGET = 40;
    localparam int MEM_AW       = $clog2(`MEM_WORDS);
    localparam int WORD_BYTES   = `WORD_WIDTH / 8;

    logic                   clk_i;
    logic                   rst_ni;
    logic                   aw_valid_i, aw_ready_o;
    axi_id_t                aw_id_i;
    logic [`ADDR_WIDTH-1:0] aw_addr_i;
    logic                   w_valid_i, w_ready_o;
    beat_t                  w_data_i;
    beat_strb_t             w_strb_i;
    logic                   b_valid_o, b_ready_i;
    axi_id_t                b_id_o;
    logic [1:0]             b_resp_o;
    logic                   ar_valid_i, ar_ready_o;
    axi_id_t                ar_id_i;
    logic [`ADDR_WIDTH-1:0] ar_addr_i;
    logic                   r_valid_o, r_ready_i, r_last_o;
    axi_id_t                r_id_o;
    beat_t                  r_data_o;
    logic [1:0]             r_resp_o;

    // reference copy of the cache contents
    word_t ref_mem [`MEM_WORDS] = '{default: '0};

    dcache_adapter_top uut (.*);

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    task automatic fail_now();
        $display("Result: FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_beat(input string name, input beat_t got, input beat_t exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            fail_now();
        end
    endtask

    task automatic check_id(input string name, input axi_id_t got, input axi_id_t exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            fail_now();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            fail_now();
        end
    endtask

    function automatic beat_t rand_beat();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    // word w of a beat lives in the slot after word w-1, wrapping at the depth
    function automatic logic [MEM_AW-1:0] slot_of(input logic [`ADDR_WIDTH-1:0] addr,
                                                  input int w);
        return MEM_AW'((addr >> 2) + w);
    endfunction

    task automatic ref_write(input logic [`ADDR_WIDTH-1:0] addr, input beat_t data,
                             input beat_strb_t strb);
        for (int w = 0; w < `WORDS_PER_BEAT; w++) begin
            for (int b = 0; b < WORD_BYTES; b++) begin
                if (strb[WORD_BYTES*w+b]) begin
                    ref_mem[slot_of(addr, w)][8*b +: 8] = data[`WORD_WIDTH*w+8*b +: 8];
                end
            end
        end
    endtask

    function automatic beat_t ref_read(input logic [`ADDR_WIDTH-1:0] addr);
        beat_t beat;
        for (int w = 0; w < `WORDS_PER_BEAT; w++) begin
            beat[`WORD_WIDTH*w +: `WORD_WIDTH] = ref_mem[slot_of(addr, w)];
        end
        return beat;
    endfunction

    // all drive tasks start and end on a falling edge
    task automatic send_aw(input logic [`ADDR_WIDTH-1:0] addr, input axi_id_t id);
        aw_valid_i = 1'b1;
        aw_id_i    = id;
        aw_addr_i  = addr;
        while (!aw_ready_o) @(negedge clk_i);
        @(negedge clk_i);
        aw_valid_i = 1'b0;
    endtask

    task automatic send_w(input beat_t data, input beat_strb_t strb);
        w_valid_i = 1'b1;
        w_data_i  = data;
        w_strb_i  = strb;
        while (!w_ready_o) @(negedge clk_i);
        @(negedge clk_i);
        w_valid_i = 1'b0;
    endtask

    task automatic send_ar(input logic [`ADDR_WIDTH-1:0] addr, input axi_id_t id);
        ar_valid_i = 1'b1;
        ar_id_i    = id;
        ar_addr_i  = addr;
        while (!ar_ready_o) @(negedge clk_i);
        @(negedge clk_i);
        ar_valid_i = 1'b0;
    endtask

    // hold keeps ready low that many cycles once the response shows up
    task automatic take_b(input axi_id_t id, input int hold);
        while (!b_valid_o) @(negedge clk_i);
        repeat (hold) begin
            @(negedge clk_i);
            check_flag("b_valid_o", b_valid_o, 1'b1);
            check_id("b_id_o", b_id_o, id);
        end
        check_id("b_id_o", b_id_o, id);
        b_ready_i = 1'b1;
        @(negedge clk_i);
        b_ready_i = 1'b0;
    endtask

    task automatic take_r(input axi_id_t id, input int hold, output beat_t got);
        while (!r_valid_o) @(negedge clk_i);
        got = r_data_o;
        repeat (hold) begin
            @(negedge clk_i);
            check_flag("r_valid_o", r_valid_o, 1'b1);
            check_id("r_id_o", r_id_o, id);
            check_beat("r_data_o", r_data_o, got);
        end
        check_id("r_id_o", r_id_o, id);
        r_ready_i = 1'b1;
        @(negedge clk_i);
        r_ready_i = 1'b0;
    endtask

    task automatic write_beat(input logic [`ADDR_WIDTH-1:0] addr, input axi_id_t id,
                              input beat_t data, input beat_strb_t strb,
                              input logic w_first, input int hold);
        if (w_first) begin
            send_w(data, strb);
            send_aw(addr, id);
        end else begin
            send_aw(addr, id);
            send_w(data, strb);
        end
        take_b(id, hold);
        ref_write(addr, data, strb);
    endtask

    task automatic read_beat(input logic [`ADDR_WIDTH-1:0] addr, input axi_id_t id,
                             input int hold, output beat_t got);
        send_ar(addr, id);
        take_r(id, hold, got);
        check_beat("r_data_o", got, ref_read(addr));
    endtask

    task automatic test_reset();
        int waited = 0;
        check_flag("b_valid_o", b_valid_o, 1'b0);
        check_flag("r_valid_o", r_valid_o, 1'b0);
        while (!(aw_ready_o && w_ready_o && ar_ready_o)) begin
            if (waited == 4) begin
                $display("ready outputs did not rise within 4 cycles after reset");
                fail_now();
            end
            waited++;
            @(negedge clk_i);
        end
    endtask

    task automatic test_full_write_read();
        beat_t data;
        beat_t got;
        data = rand_beat();
        write_beat(32'h100, 4'h3, data, '1, 1'b0, 0);
        read_beat(32'h100, 4'h5, 0, got);
        check_beat("r_data_o", got, data);
    endtask

    task automatic test_partial_strobe();
        beat_t got;
        write_beat(32'h200, 4'h1, rand_beat(), '1, 1'b0, 0);
        // byte, half, byte, half per word
        write_beat(32'h200, 4'h2, rand_beat(), 16'h6138, 1'b0, 0);
        read_beat(32'h200, 4'h7, 0, got);
        // split enables fall back to word size
        write_beat(32'h200, 4'h4, rand_beat(), 16'h0C05, 1'b1, 0);
        read_beat(32'h200, 4'h6, 0, got);
    endtask

    task automatic test_ordering();
        beat_t      data;
        beat_strb_t strb;
        beat_t      got_a;
        beat_t      got_b;
        data = rand_beat();
        strb = beat_strb_t'($urandom);
        write_beat(32'h300, 4'h8, data, strb, 1'b1, 0);
        write_beat(32'h400, 4'h9, data, strb, 1'b0, 0);
        read_beat(32'h300, 4'hA, 0, got_a);
        read_beat(32'h400, 4'hB, 0, got_b);
        check_beat("r_data_o", got_b, got_a);
    endtask

    task automatic test_backpressure();
        beat_t got;
        write_beat(32'h500, 4'hC, rand_beat(), '1, 1'b0, HOLD_CYCLES);
        read_beat(32'h500, 4'hD, HOLD_CYCLES, got);
        read_beat(32'h500, 4'hE, 0, got);
    endtask

    task automatic test_random();
        logic [`ADDR_WIDTH-1:0] addr;
        axi_id_t                id;
        beat_t                  got;
        for (int i = 0; i < RAND_TRANS; i++) begin
            // small window so reads mostly hit earlier writes
            addr = 32'h1000 + (($urandom % 64) << 2);
            id   = axi_id_t'($urandom);
            if ($urandom % 2 == 1) begin
                write_beat(addr, id, rand_beat(), beat_strb_t'($urandom),
                           ($urandom % 2) == 1, 0);
            end else begin
                read_beat(addr, id, 0, got);
            end
        end
    endtask

    initial begin
        repeat (NUM_TRANS * TRANS_BUDGET) @(posedge clk_i);
        $display("watchdog timeout: tests did not finish within %0d cycles",
                 NUM_TRANS * TRANS_BUDGET);
        fail_now();
    end

    initial begin
        void'($urandom(80311));
        clk_i      = 1'b0;
        rst_ni     = 1'b0;
        aw_valid_i = 1'b0;
        aw_id_i    = '0;
        aw_addr_i  = '0;
        w_valid_i  = 1'b0;
        w_data_i   = '0;
        w_strb_i   = '0;
        b_ready_i  = 1'b0;
        ar_valid_i = 1'b0;
        ar_id_i    = '0;
        ar_addr_i  = '0;
        r_ready_i  = 1'b0;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;

        test_reset();
        test_full_write_read();
        test_partial_strobe();
        test_ordering();
        test_backpressure();
        test_random();

        $display("Result: PASSED");
        $finish;
    end

endmodule

// ==== tb_dcache_adapter_sva.sv ====
`timescale 1ns/1ps

`include "dcache_adapter_defines.svh"

module tb_dcache_adapter_sva
    import dcache_adapter_pkg::*;
(
    input logic                   clk_i,
    input logic                   rst_ni,
    input logic                   aw_valid_i,
    input logic                   aw_ready_o,
    input axi_id_t                aw_id_i,
    input logic [`ADDR_WIDTH-1:0] aw_addr_i,
    input logic                   w_valid_i,
    input logic                   w_ready_o,
    input beat_t                  w_data_i,
    input beat_strb_t             w_strb_i,
    input logic                   b_valid_o,
    input logic                   b_ready_i,
    input axi_id_t                b_id_o,
    input logic [1:0]             b_resp_o,
    input logic                   ar_valid_i,
    input logic                   ar_ready_o,
    input axi_id_t                ar_id_i,
    input logic [`ADDR_WIDTH-1:0] ar_addr_i,
    input logic                   r_valid_o,
    input logic                   r_ready_i,
    input axi_id_t                r_id_o,
    input beat_t                  r_data_o,
    input logic [1:0]             r_resp_o,
    input logic                   r_last_o
);

    // request channels hold until taken
    aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        aw_valid_i && !aw_ready_o |=> aw_valid_i && $stable({aw_id_i, aw_addr_i}))
        else $error("aw payload changed before it was taken");
    w_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        w_valid_i && !w_ready_o |=> w_valid_i && $stable({w_data_i, w_strb_i}))
        else $error("w payload changed before it was taken");
    ar_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ar_valid_i && !ar_ready_o |=> ar_valid_i && $stable({ar_id_i, ar_addr_i}))
        else $error("ar payload changed before it was taken");

    // responses hold while stalled
    b_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_id_o))
        else $error("b response changed while stalled");
    r_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        r_valid_o && !r_ready_i |=> r_valid_o && $stable({r_id_o, r_data_o}))
        else $error("r response changed while stalled");

    // single beat, so every r is last
    r_is_last: assert property (@(posedge clk_i) disable iff (!rst_ni)
        r_valid_o |-> r_last_o)
        else $error("r beat without last");
    resp_okay: assert property (@(posedge clk_i) disable iff (!rst_ni)
        b_resp_o == 2'b00 && r_resp_o == 2'b00)
        else $error("response code other than okay");

    ctrl_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !$isunknown({aw_ready_o, w_ready_o, ar_ready_o, b_valid_o, r_valid_o}))
        else $error("unknown value on a handshake output");
    b_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
        b_valid_o |-> !$isunknown({b_id_o, b_resp_o}))
        else $error("unknown value on the b payload");
    r_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
        r_valid_o |-> !$isunknown({r_id_o, r_data_o, r_resp_o, r_last_o}))
        else $error("unknown value on the r payload");

endmodule

bind dcache_adapter_top tb_dcache_adapter_sva u_sva (.*);

// ==== dcache_adapter_top.sv ====
`timescale 1ns/1ps

`include "dcache_adapter_defines.svh"

module dcache_adapter_top
    import dcache_adapter_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   aw_valid_i,
    output logic                   aw_ready_o,
    input  axi_id_t                aw_id_i,
    input  logic [`ADDR_WIDTH-1:0] aw_addr_i,
    input  logic                   w_valid_i,
    output logic                   w_ready_o,
    input  beat_t                  w_data_i,
    input  beat_strb_t             w_strb_i,
    output logic                   b_valid_o,
    input  logic                   b_ready_i,
    output axi_id_t                b_id_o,
    output logic [1:0]             b_resp_o,
    input  logic                   ar_valid_i,
    output logic                   ar_ready_o,
    input  axi_id_t                ar_id_i,
    input  logic [`ADDR_WIDTH-1:0] ar_addr_i,
    output logic                   r_valid_o,
    input  logic                   r_ready_i,
    output axi_id_t                r_id_o,
    output beat_t                  r_data_o,
    output logic [1:0]             r_resp_o,
    output logic                   r_last_o
);

    axi_port_if    skid_axi ();
    axi_port_if    adapter_axi ();
    dcache_port_if dcache_bus ();

    assign skid_axi.aw_valid = aw_valid_i;
    assign skid_axi.aw_id    = aw_id_i;
    assign skid_axi.aw_addr  = aw_addr_i;
    assign aw_ready_o        = skid_axi.aw_ready;

    assign skid_axi.w_valid = w_valid_i;
    assign skid_axi.w_data  = w_data_i;
    assign skid_axi.w_strb  = w_strb_i;
    assign w_ready_o        = skid_axi.w_ready;

    assign skid_axi.b_ready = b_ready_i;
    assign b_valid_o        = skid_axi.b_valid;
    assign b_id_o           = skid_axi.b_id;
    assign b_resp_o         = skid_axi.b_resp;

    assign skid_axi.ar_valid = ar_valid_i;
    assign skid_axi.ar_id    = ar_id_i;
    assign skid_axi.ar_addr  = ar_addr_i;
    assign ar_ready_o        = skid_axi.ar_ready;

    assign skid_axi.r_ready = r_ready_i;
    assign r_valid_o        = skid_axi.r_valid;
    assign r_id_o           = skid_axi.r_id;
    assign r_data_o         = skid_axi.r_data;
    assign r_resp_o         = skid_axi.r_resp;
    assign r_last_o         = skid_axi.r_last;

    axi_skid_buffer u_skid (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .slv    (skid_axi.slave),
        .mst    (adapter_axi.master)
    );

    axi_dcache_adapter u_adapter (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .axi    (adapter_axi.slave),
        .dcache (dcache_bus.requester)
    );

    dcache_word_mem u_mem (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .dcache (dcache_bus.cache)
    );

endmodule

// ==== dcache_word_mem.sv ====
`timescale 1ns/1ps

`include "dcache_adapter_defines.svh"

module dcache_word_mem
    import dcache_adapter_pkg::*;
(
    input logic          clk_i,
    input logic          rst_ni,
    dcache_port_if.cache dcache
);

    localparam int unsigned OffBits = $clog2(`WORD_WIDTH / 8);
    localparam int unsigned MemAw   = $clog2(`MEM_WORDS);
    localparam int unsigned IdxBits = `INDEX_WIDTH - OffBits;
    localparam int unsigned TagBits = MemAw - IdxBits;

    word_t              mem_q [`MEM_WORDS];
    logic [IdxBits-1:0] rd_index_q;
    logic               wait_tag_q;
    logic               rvalid_q;
    word_t              rdata_q;
    logic [MemAw-1:0]   wr_addr;
    logic [MemAw-1:0]   rd_addr;
    logic               req_fire;

    // no new request while a read still waits for its tag
    assign dcache.data_gnt = !wait_tag_q;
    assign req_fire        = dcache.data_req && !wait_tag_q;

    // low tag bits select the upper half of the array
    assign wr_addr = {dcache.address_tag[TagBits-1:0],
                      dcache.address_index[`INDEX_WIDTH-1:OffBits]};
    assign rd_addr = {dcache.address_tag[TagBits-1:0], rd_index_q};

    assign dcache.data_rvalid = rvalid_q;
    assign dcache.data_rdata  = rdata_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < `MEM_WORDS; i++) begin
                mem_q[i] <= '0;
            end
            rd_index_q <= '0;
            wait_tag_q <= 1'b0;
            rvalid_q   <= 1'b0;
            rdata_q    <= '0;
        end else begin
            rvalid_q <= 1'b0;
            if (req_fire && dcache.data_we) begin
                for (int b = 0; b < `WORD_WIDTH / 8; b++) begin
                    if (dcache.data_be[b]) begin
                        mem_q[wr_addr][8*b +: 8] <= dcache.data_wdata[8*b +: 8];
                    end
                end
            end
            if (req_fire && !dcache.data_we) begin
                wait_tag_q <= 1'b1;
                rd_index_q <= dcache.address_index[`INDEX_WIDTH-1:OffBits];
            end
            // lookup happens once the tag shows up
            if (wait_tag_q && dcache.tag_valid) begin
                wait_tag_q <= 1'b0;
                rdata_q    <= mem_q[rd_addr];
                rvalid_q   <= 1'b1;
            end
        end
    end

endmodule

// ==== axi_dcache_adapter.sv ====
`timescale 1ns/1ps

`include "dcache_adapter_defines.svh"

module axi_dcache_adapter
    import dcache_adapter_pkg::*;
(
    input logic            clk_i,
    input logic            rst_ni,
    axi_port_if.slave      axi,
    dcache_port_if.requester dcache
);

    localparam int unsigned CntWidth  = $clog2(`WORDS_PER_BEAT) + 1;
    localparam int unsigned BeWidth   = `WORD_WIDTH / 8;
    localparam int unsigned WordBytes = `WORD_WIDTH / 8;

    axi_id_t             id_q, id_d;
    dcache_addr_u        addr_q, addr_d;
    dcache_addr_u        tag_addr;
    beat_t               data_q, data_d;
    beat_strb_t          strb_q, strb_d;
    logic [CntWidth-1:0] req_cnt_q, req_cnt_d;
    logic [CntWidth-1:0] rsp_cnt_q, rsp_cnt_d;
    logic                tag_pend_q, tag_pend_d;
    logic                aw_done_q, aw_done_d;
    logic                w_done_q, w_done_d;
    logic                ar_done_q, ar_done_d;
    logic                idle;
    logic                wr_go;
    logic                rd_go;

    // non-contiguous enables fall back to a word access
    function automatic data_size_t size_of(input word_be_t be);
        case (be)
            4'b0001, 4'b0010, 4'b0100, 4'b1000: return SIZE_BYTE;
            4'b0011, 4'b0110, 4'b1100:          return SIZE_HALF;
            default:                            return SIZE_WORD;
        endcase
    endfunction

    assign idle = !aw_done_q && !w_done_q && !ar_done_q;

    // a read wins when both arrive at an idle adapter
    assign axi.ar_ready = idle;
    assign axi.aw_ready = !aw_done_q && !ar_done_q && !(idle && axi.ar_valid);
    assign axi.w_ready  = !w_done_q && !ar_done_q && !(idle && axi.ar_valid);

    assign axi.b_valid = aw_done_q && w_done_q && (req_cnt_q == `WORDS_PER_BEAT);
    assign axi.b_id    = id_q;
    assign axi.b_resp  = 2'b00;

    assign axi.r_valid = ar_done_q && (rsp_cnt_q == `WORDS_PER_BEAT);
    assign axi.r_id    = id_q;
    assign axi.r_data  = data_q;
    assign axi.r_resp  = 2'b00;
    assign axi.r_last  = 1'b1;

    // tag cycle belongs to the word granted one cycle earlier
    assign tag_addr.flat = addr_q.flat - `ADDR_WIDTH'(WordBytes);

    always_comb begin
        id_d       = id_q;
        addr_d     = addr_q;
        data_d     = data_q;
        strb_d     = strb_q;
        req_cnt_d  = req_cnt_q;
        rsp_cnt_d  = rsp_cnt_q;
        tag_pend_d = 1'b0;
        aw_done_d  = aw_done_q;
        w_done_d   = w_done_q;
        ar_done_d  = ar_done_q;

        if (axi.aw_valid && axi.aw_ready) begin
            id_d        = axi.aw_id;
            addr_d.flat = axi.aw_addr;
            aw_done_d   = 1'b1;
        end
        if (axi.w_valid && axi.w_ready) begin
            data_d   = axi.w_data;
            strb_d   = axi.w_strb;
            w_done_d = 1'b1;
        end
        if (axi.ar_valid && axi.ar_ready) begin
            id_d        = axi.ar_id;
            addr_d.flat = axi.ar_addr;
            ar_done_d   = 1'b1;
        end

        wr_go = aw_done_d && w_done_d && (req_cnt_q < `WORDS_PER_BEAT);
        rd_go = ar_done_d && (req_cnt_q < `WORDS_PER_BEAT);

        dcache.tag_valid     = tag_pend_q;
        dcache.address_tag   = tag_pend_q ? tag_addr.parts.tag : '0;
        dcache.address_index = addr_d.parts.index;
        dcache.data_req      = wr_go || rd_go;
        dcache.data_we       = wr_go;
        dcache.data_be       = '1;
        dcache.data_size     = SIZE_WORD;
        dcache.data_wdata    = '0;
        dcache.data_id       = id_d;

        if (wr_go) begin
            // writes carry their tag with the request
            dcache.address_tag = addr_d.parts.tag;
            dcache.data_be     = strb_d[BeWidth-1:0];
            dcache.data_size   = size_of(strb_d[BeWidth-1:0]);
            dcache.data_wdata  = data_d[`WORD_WIDTH-1:0];
        end

        if ((wr_go || rd_go) && dcache.data_gnt) begin
            addr_d.flat = addr_d.flat + `ADDR_WIDTH'(WordBytes);
            req_cnt_d   = req_cnt_q + CntWidth'(1);
            tag_pend_d  = rd_go;
            if (wr_go) begin
                data_d = data_d >> `WORD_WIDTH;
                strb_d = strb_d >> BeWidth;
            end
        end

        // returned words enter at the top so word 0 ends lowest
        if (dcache.data_rvalid) begin
            data_d    = {dcache.data_rdata, data_d[`BEAT_WIDTH-1:`WORD_WIDTH]};
            rsp_cnt_d = rsp_cnt_q + CntWidth'(1);
        end

        if ((axi.b_valid && axi.b_ready) || (axi.r_valid && axi.r_ready)) begin
            aw_done_d  = 1'b0;
            w_done_d   = 1'b0;
            ar_done_d  = 1'b0;
            req_cnt_d  = '0;
            rsp_cnt_d  = '0;
            tag_pend_d = 1'b0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req_cnt_q  <= '0;
            rsp_cnt_q  <= '0;
            tag_pend_q <= 1'b0;
            aw_done_q  <= 1'b0;
            w_done_q   <= 1'b0;
            ar_done_q  <= 1'b0;
        end else begin
            req_cnt_q  <= req_cnt_d;
            rsp_cnt_q  <= rsp_cnt_d;
            tag_pend_q <= tag_pend_d;
            aw_done_q  <= aw_done_d;
            w_done_q   <= w_done_d;
            ar_done_q  <= ar_done_d;
        end
    end

    always_ff @(posedge clk_i) begin
        id_q   <= id_d;
        addr_q <= addr_d;
        data_q <= data_d;
        strb_q <= strb_d;
    end

endmodule

// ==== axi_skid_buffer.sv ====
`timescale 1ns/1ps

`include "dcache_adapter_defines.svh"

module axi_skid_buffer (
    input logic    clk_i,
    input logic    rst_ni,
    axi_port_if.slave  slv,
    axi_port_if.master mst
);

    localparam int unsigned AxW  = `ID_WIDTH + `ADDR_WIDTH;
    localparam int unsigned WW   = `BEAT_WIDTH + `BEAT_WIDTH / 8;
    localparam int unsigned PayW = (WW > AxW) ? WW : AxW;

    // channel 0 is AW, 1 is W, 2 is AR
    logic [2:0]      in_valid;
    logic [2:0]      in_ready;
    logic [2:0]      out_valid;
    logic [2:0]      out_ready;
    logic [PayW-1:0] in_pay  [3];
    logic [PayW-1:0] out_pay [3];

    assign in_valid  = {slv.ar_valid, slv.w_valid, slv.aw_valid};
    assign out_ready = {mst.ar_ready, mst.w_ready, mst.aw_ready};
    assign in_pay[0] = PayW'({slv.aw_id, slv.aw_addr});
    assign in_pay[1] = PayW'({slv.w_data, slv.w_strb});
    assign in_pay[2] = PayW'({slv.ar_id, slv.ar_addr});

    for (genvar c = 0; c < 3; c++) begin : g_chan
        logic            main_valid_q;
        logic            main_valid_d;
        logic            spill_valid_q;
        logic            spill_valid_d;
        logic            ready_q;
        logic [PayW-1:0] main_q;
        logic [PayW-1:0] main_d;
        logic [PayW-1:0] spill_q;
        logic [PayW-1:0] spill_d;
        logic            push;
        logic            pop;

        // ready is a flop, so push never lands on a full spill slot
        assign push = in_valid[c] && ready_q;
        assign pop  = main_valid_q && out_ready[c];

        always_comb begin
            main_valid_d  = main_valid_q;
            main_d        = main_q;
            spill_valid_d = spill_valid_q;
            spill_d       = spill_q;
            if (pop || !main_valid_q) begin
                if (spill_valid_q) begin
                    main_valid_d  = 1'b1;
                    main_d        = spill_q;
                    spill_valid_d = 1'b0;
                end else begin
                    main_valid_d = push;
                    main_d       = in_pay[c];
                end
            end else if (push) begin
                spill_valid_d = 1'b1;
                spill_d       = in_pay[c];
            end
        end

        always_ff @(posedge clk_i or negedge rst_ni) begin
            if (!rst_ni) begin
                main_valid_q  <= 1'b0;
                spill_valid_q <= 1'b0;
                ready_q       <= 1'b0;
            end else begin
                main_valid_q  <= main_valid_d;
                spill_valid_q <= spill_valid_d;
                ready_q       <= !spill_valid_d;
            end
        end

        always_ff @(posedge clk_i) begin
            main_q  <= main_d;
            spill_q <= spill_d;
        end

        assign in_ready[c]  = ready_q;
        assign out_valid[c] = main_valid_q;
        assign out_pay[c]   = main_q;
    end

    assign slv.aw_ready = in_ready[0];
    assign slv.w_ready  = in_ready[1];
    assign slv.ar_ready = in_ready[2];

    assign mst.aw_valid = out_valid[0];
    assign mst.w_valid  = out_valid[1];
    assign mst.ar_valid = out_valid[2];

    assign {mst.aw_id, mst.aw_addr} = out_pay[0][AxW-1:0];
    assign {mst.w_data, mst.w_strb} = out_pay[1][WW-1:0];
    assign {mst.ar_id, mst.ar_addr} = out_pay[2][AxW-1:0];

    // responses pass straight through
    assign slv.b_valid = mst.b_valid;
    assign slv.b_id    = mst.b_id;
    assign slv.b_resp  = mst.b_resp;
    assign mst.b_ready = slv.b_ready;

    assign slv.r_valid = mst.r_valid;
    assign slv.r_id    = mst.r_id;
    assign slv.r_data  = mst.r_data;
    assign slv.r_resp  = mst.r_resp;
    assign slv.r_last  = mst.r_last;
    assign mst.r_ready = slv.r_ready;

endmodule

// ==== dcache_port_if.sv ====
`timescale 1ns/1ps

`include "dcache_adapter_defines.svh"

interface dcache_port_if
    import dcache_adapter_pkg::*;
();

    // request side
    logic [`INDEX_WIDTH-1:0]             address_index;
    logic [`ADDR_WIDTH-`INDEX_WIDTH-1:0] address_tag;
    logic                                tag_valid;
    logic                                data_req;
    logic                                data_we;
    word_be_t                            data_be;
    data_size_t                          data_size;
    word_t                               data_wdata;
    axi_id_t                             data_id;

    // response side
    logic  data_gnt;
    logic  data_rvalid;
    word_t data_rdata;

    modport requester (
        output address_index, address_tag, tag_valid, data_req, data_we,
        output data_be, data_size, data_wdata, data_id,
        input  data_gnt, data_rvalid, data_rdata
    );

    modport cache (
        input  address_index, address_tag, tag_valid, data_req, data_we,
        input  data_be, data_size, data_wdata, data_id,
        output data_gnt, data_rvalid, data_rdata
    );

endinterface

// ==== axi_port_if.sv ====
`timescale 1ns/1ps

`include "dcache_adapter_defines.svh"

interface axi_port_if
    import dcache_adapter_pkg::*;
();

    logic                   aw_valid;
    logic                   aw_ready;
    axi_id_t                aw_id;
    logic [`ADDR_WIDTH-1:0] aw_addr;

    logic       w_valid;
    logic       w_ready;
    beat_t      w_data;
    beat_strb_t w_strb;

    logic       b_valid;
    logic       b_ready;
    axi_id_t    b_id;
    logic [1:0] b_resp;

    logic                   ar_valid;
    logic                   ar_ready;
    axi_id_t                ar_id;
    logic [`ADDR_WIDTH-1:0] ar_addr;

    logic       r_valid;
    logic       r_ready;
    axi_id_t    r_id;
    beat_t      r_data;
    logic [1:0] r_resp;
    logic       r_last;

    modport slave (
        input  aw_valid, aw_id, aw_addr, w_valid, w_data, w_strb, b_ready,
        input  ar_valid, ar_id, ar_addr, r_ready,
        output aw_ready, w_ready, b_valid, b_id, b_resp, ar_ready,
        output r_valid, r_id, r_data, r_resp, r_last
    );

    modport master (
        output aw_valid, aw_id, aw_addr, w_valid, w_data, w_strb, b_ready,
        output ar_valid, ar_id, ar_addr, r_ready,
        input  aw_ready, w_ready, b_valid, b_id, b_resp, ar_ready,
        input  r_valid, r_id, r_data, r_resp, r_last
    );

endinterface

// ==== dcache_adapter_pkg.sv ====
`include "dcache_adapter_defines.svh"

package dcache_adapter_pkg;

    // single cache word and its byte enable
    typedef logic [`WORD_WIDTH-1:0]   word_t;
    typedef logic [`WORD_WIDTH/8-1:0] word_be_t;

    // full AXI beat and its strobe
    typedef logic [`BEAT_WIDTH-1:0]   beat_t;
    typedef logic [`BEAT_WIDTH/8-1:0] beat_strb_t;

    typedef logic [`ID_WIDTH-1:0] axi_id_t;

    // access size as seen by the cache
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } data_size_t;

    // the cache splits the address into an index sent with the
    // request and a tag that may follow later
    typedef union packed {
        logic [`ADDR_WIDTH-1:0] flat;
        struct packed {
            logic [`ADDR_WIDTH-`INDEX_WIDTH-1:0] tag;
            logic [`INDEX_WIDTH-1:0]             index;
        } parts;
    } dcache_addr_u;

endpackage

// ==== dcache_adapter_defines.svh ====
`ifndef DCACHE_ADAPTER_DEFINES_SVH
`define DCACHE_ADAPTER_DEFINES_SVH

// byte address, same on AXI and on the cache port
`define ADDR_WIDTH 32

// low address bits sent with the cache request
`define INDEX_WIDTH 12

// one AXI data beat
`define BEAT_WIDTH 128

// one cache access
`define WORD_WIDTH 32

// cache words per AXI beat
`define WORDS_PER_BEAT 4

// AXI id, reused as cache transaction id
`define ID_WIDTH 4

// depth of the behavioural cache
`define MEM_WORDS 2048

`endif
